// File: verilog/softmax_settings.svh
// Softmax engine build settings
// Element format, tile geometry and vector length

`ifndef SOFTMAX_SETTINGS_SVH
`define SOFTMAX_SETTINGS_SVH

// Q16.16 element format
`define SM_WIDTH 32
`define SM_FRAC 16

// Vector geometry, SM_TOTAL is a whole number of tiles
`define SM_TILE 4
`define SM_TOTAL 16
`define SM_TILES (`SM_TOTAL / `SM_TILE)

// Sum of SM_TOTAL exps needs headroom above one element
`define SM_SUM_WIDTH (`SM_WIDTH + $clog2(`SM_TOTAL + 1))

`endif

// File: verilog/softmax_pkg.sv
// Softmax engine shared types
// Element, tile and sum formats plus the FSM and lane opcode encodings

`include "softmax_settings.svh"

package softmax_pkg;

    // Buffer address, one bit minimum for single-tile vectors
    localparam int SM_ADDR_W = (`SM_TILES > 1) ? $clog2(`SM_TILES) : 1;

    typedef logic signed [`SM_WIDTH-1:0] elem_t;                // Q16.16
    typedef logic [0:`SM_TILE-1][`SM_WIDTH-1:0] tile_t;         // Element 0 in MS chunk
    typedef logic [`SM_SUM_WIDTH-1:0] sum_t;                    // Unsigned, Q16 scale
    typedef logic [SM_ADDR_W-1:0] addr_t;

    // Pass sequencer states
    typedef enum logic [2:0] {
        st_idle,
        st_load,     // Store tiles, track the maximum
        st_sum,      // Re-read tiles for the exp sum
        st_wait_ln,
        st_norm,     // Re-read tiles for the output
        st_done
    } sm_state_e;

    // What the result stage does with a lane tile
    typedef enum logic {
        op_sum,
        op_norm
    } lane_op_e;

    localparam elem_t ONE_Q     = elem_t'(1 << `SM_FRAC);
    localparam elem_t LN2_Q     = 45426;    // 0.693147
    localparam elem_t INV_LN2_Q = 94548;    // 1.442695

endpackage

// File: verilog/softmax_if.sv
// Internal buses of the softmax engine
// tile_rd_if links the sequencer to the tile buffer, lane_op_if links the tile stages

interface tile_rd_if import softmax_pkg::*; ();
    logic  wr_en;
    addr_t wr_addr;
    tile_t wr_data;
    addr_t rd_addr;
    tile_t rd_data;     // Valid one cycle after rd_addr

    modport master (output wr_en, wr_addr, wr_data, rd_addr, input rd_data);
    modport slave (input wr_en, wr_addr, wr_data, rd_addr, output rd_data);
endinterface

// Valid-only tile stream, one tile per cycle while valid is high
interface lane_op_if import softmax_pkg::*; ();
    logic     valid;
    lane_op_e op;
    logic     last;       // Final tile of the pass
    tile_t    tile;
    elem_t    offset;     // Subtracted from every element

    modport issue (output valid, op, last, tile, offset);
    modport stage (input valid, op, last, tile, offset);
    modport sink (input valid, op, last, tile, offset);
endinterface

// File: verilog/tile_buffer.sv
// Tile buffer
// Holds one input vector as SM_TILES tiles, one write and one registered read port

`include "softmax_settings.svh"

module tile_buffer import softmax_pkg::*; (
    input logic       clk,
    tile_rd_if.slave  port
);

    tile_t mem [`SM_TILES];

    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            mem[port.wr_addr] <= port.wr_data;
        end
    end

    // Read data follows the address by one cycle
    always_ff @(posedge clk) begin
        port.rd_data <= mem[port.rd_addr];
    end

endmodule

// File: verilog/exp_lane.sv
// Fixed-point exp for one lane
// Range reduction by ln2 and a second-order polynomial, input must be <= 0

`include "softmax_settings.svh"

module exp_lane import softmax_pkg::*; (
    input  elem_t d,
    output elem_t y
);

    logic signed [63:0] d_ext;
    logic signed [63:0] k;          // Whole multiples of ln2 in -d
    logic signed [63:0] r;          // Remainder in (-ln2, 0]
    logic signed [63:0] p;
    logic signed [63:0] p_shr;

    always_comb begin
        d_ext = d;
        k     = (-d_ext * INV_LN2_Q) >>> (2 * `SM_FRAC);
        r     = d_ext + k * LN2_Q;

        // exp(r) ~ 1 + r + r^2/2
        p     = ONE_Q + r + ((r * r) >>> (`SM_FRAC + 1));

        // exp(d) = exp(r) / 2^k
        p_shr = p >>> k;
        if (k >= 31) begin
            y = '0;                 // Underflows Q16.16
        end else begin
            y = p_shr[`SM_WIDTH-1:0];
        end
    end

endmodule

// File: verilog/ln_unit.sv
// Fixed-point natural log of the exp sum
// Normalizes to [1,2) by the leading one, then a third-order series plus n*ln2

`include "softmax_settings.svh"

module ln_unit import softmax_pkg::*; (
    input  sum_t  s,
    output elem_t y
);

    localparam logic signed [63:0] THIRD_Q = 64'sd21845;   // 1/3

    int                 lead;
    int                 n;
    logic signed [63:0] m;
    logic signed [63:0] t;
    logic signed [63:0] t_sq;
    logic signed [63:0] t_cube;
    logic signed [63:0] acc;

    always_comb begin
        lead = 0;
        for (int i = 0; i < `SM_SUM_WIDTH; i++) begin
            if (s[i]) begin
                lead = i;
            end
        end
        n = (lead > `SM_FRAC) ? lead - `SM_FRAC : 0;

        m      = {{(64-`SM_SUM_WIDTH){1'b0}}, s >> n};    // Mantissa in [1,2)
        t      = m - ONE_Q;
        t_sq   = (t * t) >>> `SM_FRAC;
        t_cube = (t_sq * t) >>> `SM_FRAC;

        // ln(1+t) ~ t - t^2/2 + t^3/3
        acc = t - ((t * t) >>> (`SM_FRAC + 1)) + ((t_cube * THIRD_Q) >>> `SM_FRAC);
        acc = acc + n * LN2_Q;
        y   = acc[`SM_WIDTH-1:0];
    end

endmodule

// File: verilog/softmax_decode.sv
// Softmax pass sequencer
// Loads tiles while tracking the maximum, then replays the buffer for the sum
// and normalize passes with the matching offset

`include "softmax_settings.svh"

module softmax_decode import softmax_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  tile_t      tile_in,
    input  logic       tile_in_valid,
    input  elem_t      ln_value,
    input  logic       ln_valid,
    tile_rd_if.master  buf_bus,
    lane_op_if.issue   issue
);

    localparam addr_t LAST_TILE = addr_t'(`SM_TILES - 1);
    localparam elem_t MIN_ELEM  = elem_t'({1'b1, {(`SM_WIDTH-1){1'b0}}});

    sm_state_e state;
    addr_t     tile_cnt;        // Tiles stored so far
    addr_t     rd_addr;
    elem_t     max_val;
    elem_t     tile_max;
    elem_t     offset;
    logic      issue_valid;
    lane_op_e  issue_op;
    logic      issue_last;
    logic      over_offset;     // Replayed tile holds an element above the offset

    // Largest element of the arriving tile
    always_comb begin
        tile_max = elem_t'(tile_in[0]);
        for (int i = 1; i < `SM_TILE; i++) begin
            if (elem_t'(tile_in[i]) > tile_max) begin
                tile_max = elem_t'(tile_in[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= st_idle;
            tile_cnt    <= '0;
            rd_addr     <= '0;
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        state    <= st_load;
                        tile_cnt <= '0;
                    end
                end
                st_load: begin
                    if (tile_in_valid) begin
                        tile_cnt <= tile_cnt + 1'b1;
                        if (tile_cnt == LAST_TILE) begin
                            state <= st_sum;
                        end
                    end
                end
                // Both replay passes walk the buffer in order, one tile per cycle
                st_sum, st_norm: begin
                    issue_valid <= 1'b1;
                    rd_addr     <= rd_addr + 1'b1;
                    if (rd_addr == LAST_TILE) begin
                        rd_addr <= '0;
                        state   <= (state == st_sum) ? st_wait_ln : st_done;
                    end
                end
                st_wait_ln: begin
                    if (ln_valid) begin
                        state <= st_norm;
                    end
                end
                st_done: state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // Maximum, offset and lane tags
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            max_val <= MIN_ELEM;
        end else if (state == st_load && tile_in_valid && tile_max > max_val) begin
            max_val <= tile_max;
        end

        if (state == st_sum) begin
            offset <= max_val;                  // Final once the load pass ends
        end else if (state == st_wait_ln && ln_valid) begin
            offset <= max_val + ln_value;
        end

        issue_op   <= (state == st_norm) ? op_norm : op_sum;
        issue_last <= (rd_addr == LAST_TILE);
    end

    // Sum pass offset has to cover every stored element
    always_comb begin
        over_offset = 1'b0;
        for (int i = 0; i < `SM_TILE; i++) begin
            if (elem_t'(buf_bus.rd_data[i]) > offset) begin
                over_offset = 1'b1;
            end
        end
    end

    assign buf_bus.wr_en   = (state == st_load) && tile_in_valid;
    assign buf_bus.wr_addr = tile_cnt;
    assign buf_bus.wr_data = tile_in;
    assign buf_bus.rd_addr = rd_addr;

    // Tile comes straight off the registered buffer read
    assign issue.valid  = issue_valid;
    assign issue.op     = issue_op;
    assign issue.last   = issue_last;
    assign issue.tile   = buf_bus.rd_data;
    assign issue.offset = offset;

    a_sum_offset_is_max: assert property (@(posedge clk) disable iff (!rst_n)
        (issue.valid && issue.op == op_sum) |-> !over_offset);

endmodule

// File: verilog/softmax_execute.sv
// Softmax lane pipeline
// Stage 1 subtracts the offset per element, stage 2 registers exp of each lane

`include "softmax_settings.svh"

module softmax_execute import softmax_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    lane_op_if.stage  in,
    lane_op_if.issue  out
);

    logic     valid_q;          // Stage 1 tags
    lane_op_e op_q;
    logic     last_q;
    tile_t    exp_y;
    logic     out_valid_q;      // Stage 2 tags
    lane_op_e out_op_q;
    logic     out_last_q;
    tile_t    out_tile_q;

    for (genvar g = 0; g < `SM_TILE; g++) begin : g_lane
        elem_t diff;
        elem_t diff_q;
        elem_t y;

        assign diff = elem_t'(in.tile[g]) - in.offset;

        // exp_lane expects a non-positive argument
        always_ff @(posedge clk) begin
            diff_q <= (diff > 0) ? '0 : diff;
        end

        exp_lane i_exp_lane (
            .d (diff_q),
            .y (y)
        );

        assign exp_y[g] = y;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q     <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            valid_q     <= in.valid;
            out_valid_q <= valid_q;
        end
    end

    always_ff @(posedge clk) begin
        op_q       <= in.op;
        last_q     <= in.last;
        out_op_q   <= op_q;
        out_last_q <= last_q;
        out_tile_q <= exp_y;
    end

    assign out.valid  = out_valid_q;
    assign out.op     = out_op_q;
    assign out.last   = out_last_q;
    assign out.tile   = out_tile_q;
    assign out.offset = '0;            // Offset already applied

    a_two_cycle_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out.valid == $past(in.valid, 2));

endmodule

// File: verilog/softmax_result.sv
// Softmax result stage
// Accumulates the exp sum, registers its log and drives the output tile stream

`include "softmax_settings.svh"

module softmax_result import softmax_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    lane_op_if.sink  sink,
    output elem_t    ln_value,
    output logic     ln_valid,
    output tile_t    tile_out,
    output logic     tile_out_valid,
    output logic     done
);

    sum_t  sum_q;
    sum_t  tile_sum;
    logic  ln_pend;         // Sum complete, log due next cycle
    elem_t ln_y;

    // Exps are never negative, zero extend each one
    always_comb begin
        tile_sum = '0;
        for (int i = 0; i < `SM_TILE; i++) begin
            tile_sum = tile_sum + sum_t'(sink.tile[i]);
        end
    end

    ln_unit i_ln_unit (
        .s (sum_q),
        .y (ln_y)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_q          <= '0;
            ln_pend        <= 1'b0;
            ln_valid       <= 1'b0;
            tile_out_valid <= 1'b0;
            done           <= 1'b0;
        end else begin
            ln_valid       <= ln_pend;
            ln_pend        <= 1'b0;
            tile_out_valid <= sink.valid && sink.op == op_norm;
            done           <= sink.valid && sink.op == op_norm && sink.last;
            if (ln_pend) begin
                sum_q <= '0;                   // Ready for the next vector
            end else if (sink.valid && sink.op == op_sum) begin
                sum_q   <= sum_q + tile_sum;
                ln_pend <= sink.last;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ln_pend) begin
            ln_value <= ln_y;
        end
        if (sink.valid && sink.op == op_norm) begin
            tile_out <= sink.tile;
        end
    end

    a_ln_not_during_output: assert property (@(posedge clk) disable iff (!rst_n)
        !(ln_valid && tile_out_valid));

endmodule

// File: verilog/softmax_top.sv
// Tiled softmax engine top level
// Sequencer, tile buffer, exp lanes and result stage behind plain tile ports

module softmax_top import softmax_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  tile_t tile_in,
    input  logic  tile_in_valid,
    output tile_t tile_out,
    output logic  tile_out_valid,
    output logic  done
);

    elem_t ln_value;
    logic  ln_valid;

    tile_rd_if rd_bus ();
    lane_op_if lane_in ();      // Sequencer to lanes
    lane_op_if lane_out ();     // Lanes to result

    softmax_decode i_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .tile_in       (tile_in),
        .tile_in_valid (tile_in_valid),
        .ln_value      (ln_value),
        .ln_valid      (ln_valid),
        .buf_bus       (rd_bus.master),
        .issue         (lane_in.issue)
    );

    tile_buffer i_tile_buffer (
        .clk  (clk),
        .port (rd_bus.slave)
    );

    softmax_execute i_execute (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (lane_in.stage),
        .out   (lane_out.issue)
    );

    softmax_result i_result (
        .clk            (clk),
        .rst_n          (rst_n),
        .sink           (lane_out.sink),
        .ln_value       (ln_value),
        .ln_valid       (ln_valid),
        .tile_out       (tile_out),
        .tile_out_valid (tile_out_valid),
        .done           (done)
    );

endmodule

// File: sim/softmax_model.svh
// Fixed-point reference model for the softmax testbench
// Range-reduced exp, normalized ln and a whole-vector softmax in Q16.16

`ifndef SOFTMAX_MODEL_SVH
`define SOFTMAX_MODEL_SVH

// exp(d) for d <= 0 as exp(r) / 2^k, k whole ln2 steps and r the remainder
function automatic elem_t exp_q16(input elem_t d);
    longint dl;
    longint k;
    longint r;
    longint p;
    dl = d;
    k  = (-dl * INV_LN2_Q) >>> (2 * `SM_FRAC);
    if (k >= 31) begin
        return '0;                                  // Below the smallest Q16 step
    end
    r = dl + k * LN2_Q;
    p = (longint'(1) << `SM_FRAC) + r + ((r * r) >>> (`SM_FRAC + 1));
    return elem_t'(p >>> k);
endfunction

// ln(s) for a Q16 sum of at least one, mantissa in [1,2) plus n*ln2
function automatic elem_t ln_of_sum(input longint s);
    int     lead;
    int     n;
    longint t;
    longint t_cube;
    longint acc;
    lead = 0;
    while ((s >> (lead + 1)) != 0) begin
        lead++;
    end
    n      = (lead > `SM_FRAC) ? lead - `SM_FRAC : 0;
    t      = (s >> n) - (longint'(1) << `SM_FRAC);
    t_cube = (((t * t) >>> `SM_FRAC) * t) >>> `SM_FRAC;
    acc    = t - ((t * t) >>> (`SM_FRAC + 1)) + ((t_cube * 21845) >>> `SM_FRAC);
    acc    = acc + longint'(n) * LN2_Q;
    return elem_t'(acc);
endfunction

// Max, exp sum and log, then every element scaled by the sum
function automatic void expected_softmax(input elem_t x [`SM_TOTAL],
                                         output elem_t y [`SM_TOTAL]);
    elem_t  mx;
    elem_t  diff;
    elem_t  ofs;
    longint sum;
    mx = x[0];
    for (int i = 1; i < `SM_TOTAL; i++) begin
        if (x[i] > mx) mx = x[i];
    end
    sum = 0;
    for (int i = 0; i < `SM_TOTAL; i++) begin
        diff = x[i] - mx;
        sum  = sum + longint'(exp_q16(diff));
    end
    ofs = mx + ln_of_sum(sum);
    for (int i = 0; i < `SM_TOTAL; i++) begin
        diff = x[i] - ofs;
        if (diff > 0) diff = '0;                    // Lanes only see non-positive input
        y[i] = exp_q16(diff);
    end
endfunction

`endif

// File: sim/softmax_tb.sv
// Softmax engine testbench
// Random vectors against the fixed-point model, plus gap and flat-vector cases

`include "softmax_settings.svh"

module softmax_tb import softmax_pkg::*; ();

    localparam int    PERIOD          = 100;
    localparam int    RESET_CYCLES    = 16;
    localparam int    QUIET_CYCLES    = 4;          // Idle cycles ahead of each start
    localparam int    NUM_RANDOM      = 20;
    localparam int    NUM_VECTORS     = NUM_RANDOM + 3;
    localparam int    WATCHDOG_CYCLES = NUM_VECTORS * (`SM_TOTAL + 40) + RESET_CYCLES
                                        + QUIET_CYCLES;
    localparam elem_t SPAN_Q          = elem_t'(8 << `SM_FRAC);     // +-8.0

    logic   clk;
    logic   rst_n;
    logic   start;
    tile_t  tile_in;
    logic   tile_in_valid;
    tile_t  tile_out;
    logic   tile_out_valid;
    logic   done;

    integer seed;
    elem_t  vec [`SM_TOTAL];
    elem_t  expect_vec [`SM_TOTAL];
    elem_t  got_vec [`SM_TOTAL];
    elem_t  gap_run [`SM_TOTAL];

    `include "softmax_model.svh"

    softmax_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .tile_in        (tile_in),
        .tile_in_valid  (tile_in_valid),
        .tile_out       (tile_out),
        .tile_out_valid (tile_out_valid),
        .done           (done)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                               input string what);
        if (got !== expected) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s, got %0d, expected %0d",
                                $time, what, $signed(got), $signed(expected)));
        end
    endtask

    task automatic expect_quiet(input string when);
        check_value(tile_out_valid, 1'b0, {"tile_out_valid ", when});
        check_value(done, 1'b0, {"done ", when});
    endtask

    // Junk the engine has to ignore outside the load pass
    task automatic drive_junk();
        for (int e = 0; e < `SM_TILE; e++) begin
            tile_in[e] = $random(seed);
        end
        tile_in_valid = ($random(seed) & 1) != 0;
    endtask

    task automatic fill_random();
        for (int i = 0; i < `SM_TOTAL; i++) begin
            vec[i] = elem_t'($random(seed) % (SPAN_Q + 1));
        end
    endtask

    // Start, load vec with optional gaps, collect the output tiles and compare
    task automatic run_vector(input bit with_gaps);
        int sent;
        int out_cnt;
        bit finished;
        bit gapped;
        expected_softmax(vec, expect_vec);
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            expect_quiet("before start");
            drive_junk();
        end
        @(negedge clk);
        expect_quiet("before start");
        start = 1'b1;
        @(negedge clk);
        expect_quiet("during load");
        start  = 1'b0;
        sent   = 0;
        gapped = 1'b0;
        while (sent < `SM_TILES) begin
            // Gap mode always leaves at least one hole before the last tile
            if (with_gaps && ((($random(seed) & 3) == 0)
                              || (sent == `SM_TILES - 1 && !gapped))) begin
                drive_junk();
                tile_in_valid = 1'b0;           // Gap cycle
                gapped        = 1'b1;
            end else begin
                for (int e = 0; e < `SM_TILE; e++) begin
                    tile_in[e] = vec[sent * `SM_TILE + e];
                end
                tile_in_valid = 1'b1;
                sent++;
            end
            @(negedge clk);
            expect_quiet("during load");
        end
        out_cnt  = 0;
        finished = 1'b0;
        while (!finished) begin
            drive_junk();
            @(negedge clk);
            if (tile_out_valid) begin
                check_value(done, out_cnt == `SM_TILES - 1, "done with the last tile");
                for (int e = 0; e < `SM_TILE; e++) begin
                    got_vec[out_cnt * `SM_TILE + e] = tile_out[e];
                end
                out_cnt++;
                finished = done;
            end else begin
                check_value(done, 1'b0, "done without an output tile");
            end
        end
        for (int i = 0; i < `SM_TOTAL; i++) begin
            check_value(got_vec[i], expect_vec[i], $sformatf("output element %0d", i));
        end
    endtask

    initial begin
        elem_t flat;
        elem_t flat_out;
        clk           = 1'b0;
        rst_n         = 1'b0;
        start         = 1'b0;
        tile_in       = '0;
        tile_in_valid = 1'b0;
        seed          = 19639;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int v = 0; v < NUM_RANDOM; v++) begin
            fill_random();
            run_vector(($random(seed) & 1) != 0);
        end

        // Same vector with and without input gaps
        fill_random();
        run_vector(1'b1);
        gap_run = got_vec;
        run_vector(1'b0);
        for (int i = 0; i < `SM_TOTAL; i++) begin
            check_value(got_vec[i], gap_run[i], $sformatf("gapless element %0d", i));
        end

        // All equal elements give 1/SM_TOTAL everywhere
        flat = elem_t'($random(seed) % (SPAN_Q + 1));
        for (int i = 0; i < `SM_TOTAL; i++) begin
            vec[i] = flat;
        end
        flat_out = exp_q16(-ln_of_sum(longint'(`SM_TOTAL) << `SM_FRAC));
        run_vector(1'b1);
        for (int i = 0; i < `SM_TOTAL; i++) begin
            check_value(got_vec[i], flat_out, $sformatf("flat element %0d", i));
        end

        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            expect_quiet("after the last vector");
        end
        $display(">>> PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        abort_run("Timeout: the softmax engine did not finish all vectors in time");
    end

endmodule

// File: softmax_top.f
+incdir+verilog
+incdir+sim
verilog/softmax_pkg.sv
verilog/softmax_if.sv
verilog/tile_buffer.sv
verilog/exp_lane.sv
verilog/ln_unit.sv
verilog/softmax_decode.sv
verilog/softmax_execute.sv
verilog/softmax_result.sv
verilog/softmax_top.sv
sim/softmax_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the softmax testbench with Verilator, run it and scan the log for a failure
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module softmax_tb \
    -f softmax_top.f -o softmax_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/softmax_sim > sim.log 2>&1
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
